//--- src.f
src/xform_pkg.sv
src/sync_fifo.sv
src/xform_stage.sv
src/xform_top.sv
dv/xform_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := xform_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
PASS_MSG := PASS: all tests

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/xform_tb.sv
`timescale 1ns/100ps

module xform_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;     // inputs change this long after the rising edge
    localparam int RST_CYCLES = 5;
    localparam int N_RAND     = 60;     // random words after the directed ones
    localparam int N_MIXED    = 300;    // cycles of mixed read/write traffic
    localparam int CAPACITY   = xform_pkg::IN_DEPTH + 1 + xform_pkg::OUT_DEPTH;
    localparam logic [31:0] SEED = 32'h73ace48c;

    // cycle budget per phase, drains included
    localparam int CYC_ORDER = 2 * (4 + N_RAND) + 20;
    localparam int CYC_LAT   = 20;
    localparam int CYC_FILL  = 2 * CAPACITY + 20;
    localparam int CYC_MIXED = N_MIXED + 2 * CAPACITY + 20;
    localparam int PLAN_CYCLES = RST_CYCLES + CYC_ORDER + CYC_LAT + CYC_FILL + CYC_MIXED;

    // one directed word per opcode, in opcode order
    localparam logic [31:0] DIR_WORD [4] = '{32'hA5A5_0F0F, 32'h1234_5678,
                                             32'hFFFF_FF00, 32'hDEAD_BEEF};

    logic                          clk;
    logic                          rst_n;
    logic                          wr_i;
    logic [xform_pkg::DATA_W-1:0]  wdata_i;
    xform_pkg::op_e                op_i;
    logic                          in_full_o;
    logic                          rd_i;
    logic [xform_pkg::DATA_W-1:0]  rdata_o;
    logic                          out_empty_o;

    logic [xform_pkg::DATA_W-1:0]  exp_q [$];   // expected results, write order
    logic [xform_pkg::DATA_W-1:0]  exp_head;    // queue front as seen by the reader
    logic                          lat_mode;    // single-write latency probe armed
    logic                          fill_mode;   // capacity fill in progress
    logic                          hold_full;   // reader idle, input must stay full
    logic                          idle_check;  // everything drained
    int                            fill_cnt;    // writes accepted during the fill
    int                            err_cnt = 0;

    xform_top xform_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (wr_i),
        .wdata_i     (wdata_i),
        .op_i        (op_i),
        .in_full_o   (in_full_o),
        .rd_i        (rd_i),
        .rdata_o     (rdata_o),
        .out_empty_o (out_empty_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // result the stream must produce for one written entry
    function automatic logic [31:0] expected_word(input xform_pkg::op_e op, input logic [31:0] w);
        logic [31:0] r;
        case (op)
            xform_pkg::OP_INV:  r = ~w;                       // all bits flipped
            xform_pkg::OP_ADD:  r = w + xform_pkg::ADD_K;     // wraps at 2^32
            xform_pkg::OP_SWAP: r = {w[15:0], w[31:16]};      // halves exchanged
            default:            r = w;
        endcase
        return r;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, exp_v, act_v);
        err_cnt++;
        abort_run();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // one cycle of traffic, strobes gated by the flags
    task automatic drive(input bit want_wr, input xform_pkg::op_e op, input logic [31:0] w,
                         input bit want_rd, output bit wrote);
        next_cycle();
        wrote   = want_wr && !in_full_o;
        wr_i    = wrote;
        op_i    = op;
        wdata_i = w;
        rd_i    = want_rd && !out_empty_o;
    endtask

    // read until every written word came back
    task automatic drain();
        bit wrote;
        do begin
            drive(1'b0, xform_pkg::OP_PASS, '0, 1'b1, wrote);  // first step lets a pending write land
        end while (exp_q.size() != 0);
    endtask

    // reference model, updated on the accepting edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (wr_i) exp_q.push_back(expected_word(op_i, wdata_i));
            if (rd_i && exp_q.size() != 0) void'(exp_q.pop_front());
            exp_head <= (exp_q.size() != 0) ? exp_q[0] : 'x;
        end
    end

    // flags at rest in reset and on the first edge after it
    a_reset_empty: assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> out_empty_o)
        else report_mismatch("out_empty_o", 32'd1, 32'($sampled(out_empty_o)));
    a_reset_full: assert property (@(posedge clk) (!rst_n || !$past(rst_n)) |-> !in_full_o)
        else report_mismatch("in_full_o", 32'd0, 32'($sampled(in_full_o)));

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n) rd_i |-> rdata_o == exp_head)
        else report_mismatch("rdata_o", $sampled(exp_head), $sampled(rdata_o));

    // write at edge e, empty still high at e+2, low at e+3
    a_lat_not_early: assert property (@(posedge clk) disable iff (!rst_n)
        $past(lat_mode && wr_i, 2) |-> out_empty_o)
        else report_mismatch("out_empty_o", 32'd1, 32'($sampled(out_empty_o)));
    a_lat_falls: assert property (@(posedge clk) disable iff (!rst_n)
        $past(lat_mode && wr_i, 3) |-> !out_empty_o)
        else report_mismatch("out_empty_o", 32'd0, 32'($sampled(out_empty_o)));

    a_fill_count: assert property (@(posedge clk) disable iff (!rst_n)
        (fill_mode && $rose(in_full_o)) |-> fill_cnt == CAPACITY)
        else report_mismatch("fill_cnt", 32'(CAPACITY), 32'($sampled(fill_cnt)));
    a_full_holds: assert property (@(posedge clk) disable iff (!rst_n) hold_full |-> in_full_o)
        else report_mismatch("in_full_o", 32'd1, 32'($sampled(in_full_o)));

    a_idle_empty: assert property (@(posedge clk) disable iff (!rst_n) idle_check |-> out_empty_o)
        else report_mismatch("out_empty_o", 32'd1, 32'($sampled(out_empty_o)));
    a_idle_full: assert property (@(posedge clk) disable iff (!rst_n) idle_check |-> !in_full_o)
        else report_mismatch("in_full_o", 32'd0, 32'($sampled(in_full_o)));

    initial begin
        #((PLAN_CYCLES + 200) * CLK_PERIOD);
        $display("** Error at %0t ns: watchdog expired, traffic never finished", $time);
        abort_run();
    end

    initial begin
        bit                  wrote;
        xform_pkg::op_e      op;
        logic [31:0]         w;
        rst_n      = 1'b0;
        wr_i       = 1'b0;
        rd_i       = 1'b0;
        wdata_i    = '0;
        op_i       = xform_pkg::OP_PASS;
        lat_mode   = 1'b0;
        fill_mode  = 1'b0;
        hold_full  = 1'b0;
        idle_check = 1'b0;
        fill_cnt   = 0;
        void'($urandom(SEED));
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // every opcode once, then a random stream, reader always ready
        for (int i = 0; i < 4 + N_RAND; i++) begin
            if (i < 4) begin
                op = xform_pkg::op_e'(i);
                w  = DIR_WORD[i];
            end else begin
                op = xform_pkg::op_e'($urandom % 4);
                w  = $urandom;
            end
            wrote = 1'b0;
            while (!wrote) drive(1'b1, op, w, 1'b1, wrote);
        end
        drain();

        // single write into an idle pipeline
        repeat (3) drive(1'b0, xform_pkg::OP_PASS, '0, 1'b0, wrote);
        lat_mode = 1'b1;
        drive(1'b1, xform_pkg::OP_SWAP, 32'h0BAD_F00D, 1'b0, wrote);
        drive(1'b0, xform_pkg::OP_PASS, '0, 1'b0, wrote);  // write edge still sees lat_mode
        lat_mode = 1'b0;
        repeat (4) drive(1'b0, xform_pkg::OP_PASS, '0, 1'b0, wrote);
        drain();

        // fill with the reader idle until the input side reports full
        fill_mode = 1'b1;
        while (!in_full_o && fill_cnt < 2 * CAPACITY) begin
            drive(1'b1, xform_pkg::op_e'($urandom % 4), $urandom, 1'b0, wrote);
            if (wrote) fill_cnt++;
        end
        hold_full = 1'b1;
        repeat (10) drive(1'b0, xform_pkg::OP_PASS, '0, 1'b0, wrote);
        hold_full = 1'b0;
        fill_mode = 1'b0;
        drain();

        // writes and reads in the same cycles
        for (int c = 0; c < N_MIXED; c++) begin
            drive(($urandom % 100) < 60, xform_pkg::op_e'($urandom % 4), $urandom,
                  ($urandom % 100) < 50, wrote);
        end
        drain();
        idle_check = 1'b1;
        repeat (4) next_cycle();

        if (err_cnt == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- src/xform_top.sv
`timescale 1ns/100ps

module xform_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // writer side
    input  logic                          wr_i,        // one-cycle write strobe
    input  logic [xform_pkg::DATA_W-1:0]  wdata_i,     // word to transform
    input  xform_pkg::op_e                op_i,        // transform to apply
    output logic                          in_full_o,   // writer must hold off while high
    // reader side
    input  logic                          rd_i,        // one-cycle read strobe
    output logic [xform_pkg::DATA_W-1:0]  rdata_o,     // head word, show-ahead
    output logic                          out_empty_o  // reader must hold off while high
);

    // input FIFO to stage
    logic                                         in_rd;
    logic [xform_pkg::OP_W+xform_pkg::DATA_W-1:0] in_rdata;   // {op, word}
    logic                                         in_empty;

    // stage to output FIFO
    logic                                         out_wr;
    logic [xform_pkg::DATA_W-1:0]                 out_wdata;
    logic                                         out_full;

    // opcode rides in the top bits of each entry
    sync_fifo #(
        .WIDTH (xform_pkg::OP_W + xform_pkg::DATA_W),
        .DEPTH (xform_pkg::IN_DEPTH)
    ) u_in_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en_i (wr_i),
        .rd_en_i (in_rd),
        .wdata_i ({op_i, wdata_i}),
        .rdata_o (in_rdata),
        .full_o  (in_full_o),
        .empty_o (in_empty)
    );

    // one-deep transform, 1 cycle from pop to push
    xform_stage u_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_rdata_i  (in_rdata),
        .in_empty_i  (in_empty),
        .in_rd_o     (in_rd),
        .out_full_i  (out_full),
        .out_wr_o    (out_wr),
        .out_wdata_o (out_wdata)
    );

    // results only, opcode already consumed
    sync_fifo #(
        .WIDTH (xform_pkg::DATA_W),
        .DEPTH (xform_pkg::OUT_DEPTH)
    ) u_out_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en_i (out_wr),
        .rd_en_i (rd_i),
        .wdata_i (out_wdata),
        .rdata_o (rdata_o),
        .full_o  (out_full),
        .empty_o (out_empty_o)
    );

endmodule

//--- src/xform_stage.sv
`timescale 1ns/100ps

module xform_stage (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [xform_pkg::OP_W+xform_pkg::DATA_W-1:0] in_rdata_i,  // {op, word} at input head
    input  logic                                     in_empty_i,  // input FIFO empty level
    output logic                                     in_rd_o,     // pop strobe to input FIFO
    input  logic                                     out_full_i,  // output FIFO full level
    output logic                                     out_wr_o,    // push strobe to output FIFO
    output logic [xform_pkg::DATA_W-1:0]             out_wdata_o  // registered result
);

    xform_pkg::stage_e               state_q;   // slot occupancy
    xform_pkg::stage_e               state_d;
    logic [xform_pkg::DATA_W-1:0]    slot_q;    // transformed word, no reset
    xform_pkg::op_e                  op;        // decoded opcode of the head entry
    logic [xform_pkg::DATA_W-1:0]    word;      // raw word of the head entry
    logic [xform_pkg::DATA_W-1:0]    result;    // transform of the head entry

    // split the head entry
    assign op   = xform_pkg::op_e'(in_rdata_i[xform_pkg::OP_W+xform_pkg::DATA_W-1:
                                              xform_pkg::DATA_W]);
    assign word = in_rdata_i[xform_pkg::DATA_W-1:0];

    // transform runs on the head entry so the slot loads the finished result
    always_comb begin
        case (op)
            xform_pkg::OP_PASS: result = word;                           // untouched
            xform_pkg::OP_INV:  result = ~word;                          // flip all bits
            xform_pkg::OP_ADD:  result = word + xform_pkg::ADD_K;        // carry out dropped
            xform_pkg::OP_SWAP: result = {word[15:0], word[31:16]};      // halves swapped
            default:            result = word;
        endcase
    end

    // push while holding a result and the output FIFO has room
    assign out_wr_o = (state_q == xform_pkg::ST_FULL) && !out_full_i;

    // pop when the slot is free now or frees up this cycle
    assign in_rd_o = !in_empty_i
                   && ((state_q == xform_pkg::ST_EMPTY) || out_wr_o);

    always_comb begin
        state_d = state_q;
        if (in_rd_o) begin
            state_d = xform_pkg::ST_FULL;        // refill, covers pop+push too
        end else if (out_wr_o) begin
            state_d = xform_pkg::ST_EMPTY;       // drained, nothing to replace it
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= xform_pkg::ST_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (in_rd_o) begin
            slot_q <= result;                    // load on the pop edge
        end
    end

    assign out_wdata_o = slot_q;                 // push data straight from the slot

    // back-pressure must freeze the slot until the output FIFO drains
    a_hold_on_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == xform_pkg::ST_FULL && out_full_i)
            |=> (state_q == xform_pkg::ST_FULL) && $stable(slot_q)
    ) else $error("xform_stage: slot changed under back-pressure");

    // never pop an empty input FIFO
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_empty_i |-> !in_rd_o
    ) else $error("xform_stage: pop while input empty");

endmodule

//--- src/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 32,  // entry width
    parameter int DEPTH = 8    // entry count, any value >= 1
) (
    input  logic             clk,
    input  logic             rst_n,    // async, active low, pointers only
    input  logic             wr_en_i,  // one-cycle push strobe
    input  logic             rd_en_i,  // one-cycle pop strobe
    input  logic [WIDTH-1:0] wdata_i,  // push data
    output logic [WIDTH-1:0] rdata_o,  // head entry, show-ahead
    output logic             full_o,   // no room left
    output logic             empty_o   // nothing stored
);

    // address bits, at least one so the pointer slices stay legal
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [AW:0]      wr_ptr_q;          // msb is the lap bit
    logic [AW:0]      rd_ptr_q;          // same layout as wr_ptr_q
    logic [AW:0]      wr_ptr_d;
    logic [AW:0]      rd_ptr_d;
    logic [WIDTH-1:0] mem_q [DEPTH];     // storage, no reset

    // step a pointer, wrap at DEPTH-1 and flip the lap bit
    function automatic logic [AW:0] ptr_inc(input logic [AW:0] ptr);
        logic [AW:0] nxt;
        if (ptr[AW-1:0] == AW'(DEPTH - 1)) begin
            nxt = {~ptr[AW], {AW{1'b0}}};  // back to slot 0, next lap
        end else begin
            nxt = ptr + (AW + 1)'(1);      // plain increment
        end
        return nxt;
    endfunction

    always_comb begin
        wr_ptr_d = wr_ptr_q;                          // hold by default
        rd_ptr_d = rd_ptr_q;
        if (wr_en_i) wr_ptr_d = ptr_inc(wr_ptr_q);    // advance tail on push
        if (rd_en_i) rd_ptr_d = ptr_inc(rd_ptr_q);    // advance head on pop
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;         // empty after reset
            rd_ptr_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_d;
            rd_ptr_q <= rd_ptr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_ptr_q[AW-1:0]] <= wdata_i;  // store at tail, same edge as strobe
        end
    end

    assign rdata_o = mem_q[rd_ptr_q[AW-1:0]];   // combinational head read

    // equal pointers on the same lap -> empty, different lap -> full
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0])
                   && (wr_ptr_q[AW] != rd_ptr_q[AW]);

    // the datapath has no overflow guard, the producer must watch full_o
    a_no_wr_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en_i |-> !full_o
    ) else $error("sync_fifo: write while full");

    // same for the consumer and empty_o
    a_no_rd_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en_i |-> !empty_o
    ) else $error("sync_fifo: read while empty");

endmodule

//--- src/xform_pkg.sv
package xform_pkg;

    // datapath widths
    localparam int DATA_W = 32;  // payload word
    localparam int OP_W   = 2;   // opcode field

    // buffer depths
    localparam int IN_DEPTH  = 8;  // entries in the input FIFO
    localparam int OUT_DEPTH = 4;  // entries in the output FIFO

    localparam logic [DATA_W-1:0] ADD_K = 32'h0000_0101;  // addend for OP_ADD

    // opcode travels next to the word in the input FIFO, upper OP_W bits
    typedef enum logic [OP_W-1:0] {
        OP_PASS = 2'd0,  // word unchanged
        OP_INV  = 2'd1,  // bitwise inverse
        OP_ADD  = 2'd2,  // word + ADD_K, wraps mod 2^32
        OP_SWAP = 2'd3   // upper and lower halves exchanged
    } op_e;

    // occupancy of the single result slot in the transform stage
    typedef enum logic {
        ST_EMPTY = 1'b0,  // nothing held
        ST_FULL  = 1'b1   // result waiting for the output FIFO
    } stage_e;

endpackage
